// ==== include/lsu_settings.svh ====
// Widths and sizes of the load/store unit, included by the package and every RTL file.
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Datapath widths.
`define LSU_DATA_WIDTH    32
`define LSU_ADDR_WIDTH    32
`define LSU_ROB_TAG_WIDTH 5

// Store queue entries.
`define LSU_SQ_DEPTH      4

// Direct-mapped data cache geometry.
`define LSU_DC_LINE_BYTES 16
`define LSU_DC_LINES      16

`endif

// ==== lsu_top.f ====
+incdir+include
source/lsu_pkg.sv
source/lsu_agu.sv
source/lsu_store_queue.sv
source/lsu_dcache.sv
source/lsu_execute.sv
source/lsu_top.sv
verification/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator, runs it and checks the log for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f lsu_top.f \
    --top-module tb_lsu_top -o sim_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
exit 1

// ==== source/lsu_agu.sv ====
// Address stage of the LSU, decodes the issued operation and forms its effective address.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_agu (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_fu_valid,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_insn,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_src_a,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_src_b,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_fu_tag,
    input  logic                          i_sq_full,
    output logic                          o_fu_stall,
    output logic                          o_rd_en,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_rd_addr,
    output logic                          o_alloc_en,
    output lsu_pkg::lsu_func_t            o_alloc_func,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_alloc_addr,
    output logic [`LSU_DATA_WIDTH-1:0]    o_alloc_data,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_alloc_tag,
    output logic                          o_valid,
    output lsu_pkg::lsu_func_t            o_func,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_addr,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_tag
);

    import lsu_pkg::*;

    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic                          accept;
    logic                          is_store;
    lsu_func_t                     dec_func;
    logic [`LSU_ADDR_WIDTH-1:0]    imm;
    logic [`LSU_ADDR_WIDTH-1:0]    eff_addr;
    logic                          valid_q;
    lsu_func_t                     func_q;
    logic [`LSU_ADDR_WIDTH-1:0]    addr_q;
    logic [`LSU_DATA_WIDTH-1:0]    data_q;
    logic [`LSU_ROB_TAG_WIDTH-1:0] tag_q;

    // Any operation waits while the store queue has no room.
    assign o_fu_stall = i_sq_full;
    assign accept     = i_fu_valid && !o_fu_stall;
    assign is_store   = (i_fu_insn[6:0] == OPC_STORE);

    always_comb begin
        if (is_store) begin
            imm = {{(`LSU_ADDR_WIDTH-12){i_fu_insn[31]}}, i_fu_insn[31:25], i_fu_insn[11:7]};
        end else begin
            imm = {{(`LSU_ADDR_WIDTH-12){i_fu_insn[31]}}, i_fu_insn[31:20]};
        end
        eff_addr = i_fu_src_a + imm;
        case ({is_store, i_fu_insn[14:12]})
            4'b0000: dec_func = LSU_LB;
            4'b0001: dec_func = LSU_LH;
            4'b0100: dec_func = LSU_LBU;
            4'b0101: dec_func = LSU_LHU;
            4'b1000: dec_func = LSU_SB;
            4'b1001: dec_func = LSU_SH;
            4'b1010: dec_func = LSU_SW;
            default: dec_func = LSU_LW;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            func_q <= dec_func;
            addr_q <= eff_addr;
            data_q <= i_fu_src_b;
            tag_q  <= i_fu_tag;
        end
    end

    assign o_valid      = valid_q;
    assign o_func       = func_q;
    assign o_addr       = addr_q;
    assign o_tag        = tag_q;
    assign o_rd_en      = valid_q && lsu_is_load(func_q);
    assign o_rd_addr    = addr_q;
    assign o_alloc_en   = valid_q && lsu_is_store(func_q);
    assign o_alloc_func = func_q;
    assign o_alloc_addr = addr_q;
    assign o_alloc_data = data_q;
    assign o_alloc_tag  = tag_q;

    // The core only issues naturally aligned accesses.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |-> !((dec_func inside {LSU_LH, LSU_LHU, LSU_SH}) && eff_addr[0]) &&
                   !((dec_func inside {LSU_LW, LSU_SW}) && (eff_addr[1:0] != 2'b00)));

endmodule

// ==== source/lsu_dcache.sv ====
// Direct-mapped write-through data cache of the LSU with a registered read port.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_dcache (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_rd_en,
    input  logic [`LSU_ADDR_WIDTH-1:0] i_rd_addr,
    input  logic                       i_fill_en,
    input  logic [`LSU_ADDR_WIDTH-1:0] i_fill_addr,
    input  lsu_pkg::dc_line_t          i_fill_data,
    input  logic                       i_st_en,
    input  logic [`LSU_ADDR_WIDTH-1:0] i_st_addr,
    input  logic [`LSU_DATA_WIDTH-1:0] i_st_data,
    input  lsu_pkg::byte_mask_t        i_st_mask,
    output logic                       o_hit,
    output logic [`LSU_DATA_WIDTH-1:0] o_rd_word
);

    import lsu_pkg::*;

    logic [`LSU_DC_LINES-1:0] valid_q;
    dc_tag_t                  tag_mem  [`LSU_DC_LINES];
    dc_line_t                 line_mem [`LSU_DC_LINES];
    dc_index_t                rd_index;
    dc_index_t                fill_index;
    dc_index_t                st_index;
    dc_tag_t                  rd_tag;
    dc_tag_t                  fill_tag;
    dc_tag_t                  st_tag;
    dc_offset_t               rd_offset;
    dc_offset_t               st_offset;
    logic                     st_hit;

    assign rd_index   = i_rd_addr[DC_OFFSET_W +: DC_INDEX_W];
    assign rd_tag     = i_rd_addr[`LSU_ADDR_WIDTH-1 -: DC_TAG_W];
    assign rd_offset  = i_rd_addr[DC_OFFSET_W-1:0];
    assign fill_index = i_fill_addr[DC_OFFSET_W +: DC_INDEX_W];
    assign fill_tag   = i_fill_addr[`LSU_ADDR_WIDTH-1 -: DC_TAG_W];
    assign st_index   = i_st_addr[DC_OFFSET_W +: DC_INDEX_W];
    assign st_tag     = i_st_addr[`LSU_ADDR_WIDTH-1 -: DC_TAG_W];
    assign st_offset  = i_st_addr[DC_OFFSET_W-1:0];

    // No allocation on a store miss.
    assign st_hit = valid_q[st_index] && (tag_mem[st_index] == st_tag);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
            o_hit   <= 1'b0;
        end else begin
            if (i_fill_en) begin
                valid_q[fill_index] <= 1'b1;
            end
            o_hit <= i_rd_en && valid_q[rd_index] && (tag_mem[rd_index] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        o_rd_word <= line_mem[rd_index][{rd_offset[DC_OFFSET_W-1:2], 5'b00000} +: 32];
        if (i_fill_en) begin
            line_mem[fill_index] <= i_fill_data;
            tag_mem[fill_index]  <= fill_tag;
        end else if (i_st_en && st_hit) begin
            for (int b = 0; b < `LSU_DATA_WIDTH/8; b++) begin
                if (i_st_mask[b]) begin
                    line_mem[st_index][{st_offset[DC_OFFSET_W-1:2], 5'b00000} + b*8 +: 8]
                        <= i_st_data[b*8 +: 8];
                end
            end
        end
    end

    // The store queue yields the write port to fills.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_fill_en && i_st_en));

endmodule

// ==== source/lsu_execute.sv ====
// Execute stage of the LSU, checks the hit, aligns load data and broadcasts the result.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_execute (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_valid,
    input  lsu_pkg::lsu_func_t            i_func,
    input  logic [`LSU_ADDR_WIDTH-1:0]    i_addr,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_tag,
    input  logic                          i_hit,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_rd_word,
    output logic                          o_cdb_en,
    output logic [`LSU_DATA_WIDTH-1:0]    o_cdb_data,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_cdb_addr,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_cdb_tag,
    output logic                          o_miss_en,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_miss_addr,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_miss_tag
);

    import lsu_pkg::*;

    logic                          s1_valid;
    lsu_func_t                     s1_func;
    logic [`LSU_ADDR_WIDTH-1:0]    s1_addr;
    logic [`LSU_ROB_TAG_WIDTH-1:0] s1_tag;
    logic [`LSU_DATA_WIDTH-1:0]    shifted;
    logic [`LSU_DATA_WIDTH-1:0]    ld_data;

    // The operation waits here one cycle to line up with the cache read.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid  <= 1'b0;
            o_cdb_en  <= 1'b0;
            o_miss_en <= 1'b0;
        end else begin
            s1_valid  <= i_valid && !i_flush;
            o_cdb_en  <= s1_valid && !i_flush && (lsu_is_store(s1_func) || i_hit);
            o_miss_en <= s1_valid && !i_flush && lsu_is_load(s1_func) && !i_hit;
        end
    end

    always_comb begin
        shifted = i_rd_word >> {s1_addr[1:0], 3'b000};
        case (s1_func)
            LSU_LB:  ld_data = {{(`LSU_DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            LSU_LBU: ld_data = {{(`LSU_DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            LSU_LH:  ld_data = {{(`LSU_DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            LSU_LHU: ld_data = {{(`LSU_DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            LSU_LW:  ld_data = shifted;
            // Stores report no data.
            default: ld_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        s1_func    <= i_func;
        s1_addr    <= i_addr;
        s1_tag     <= i_tag;
        o_cdb_data <= ld_data;
        o_cdb_addr <= s1_addr;
        o_cdb_tag  <= s1_tag;
    end

    assign o_miss_addr = o_cdb_addr;
    assign o_miss_tag  = o_cdb_tag;

    // A cache hit only answers a load that the address stage sent a cycle earlier.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_hit |-> $past(i_valid) && lsu_is_load(s1_func));

endmodule

// ==== source/lsu_pkg.sv ====
// Memory function and cache address-field types, imported by every LSU RTL file.
`include "lsu_settings.svh"

package lsu_pkg;

    localparam int DC_OFFSET_W = $clog2(`LSU_DC_LINE_BYTES);
    localparam int DC_INDEX_W  = $clog2(`LSU_DC_LINES);
    localparam int DC_TAG_W    = `LSU_ADDR_WIDTH - DC_INDEX_W - DC_OFFSET_W;

    // Encoded as {store, funct3}.
    typedef enum logic [3:0] {
        LSU_LB  = 4'b0000,
        LSU_LH  = 4'b0001,
        LSU_LW  = 4'b0010,
        LSU_LBU = 4'b0100,
        LSU_LHU = 4'b0101,
        LSU_SB  = 4'b1000,
        LSU_SH  = 4'b1001,
        LSU_SW  = 4'b1010
    } lsu_func_t;

    typedef logic [`LSU_DC_LINE_BYTES*8-1:0] dc_line_t;
    typedef logic [DC_INDEX_W-1:0]           dc_index_t;
    typedef logic [DC_TAG_W-1:0]             dc_tag_t;
    typedef logic [DC_OFFSET_W-1:0]          dc_offset_t;
    typedef logic [`LSU_DATA_WIDTH/8-1:0]    byte_mask_t;

    function automatic logic lsu_is_store(lsu_func_t func);
        return func[3];
    endfunction

    function automatic logic lsu_is_load(lsu_func_t func);
        return !func[3];
    endfunction

endpackage

// ==== source/lsu_store_queue.sv ====
// In-order store buffer of the LSU, holds stores until ROB retirement and then drains them.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_store_queue (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_alloc_en,
    input  lsu_pkg::lsu_func_t            i_alloc_func,
    input  logic [`LSU_ADDR_WIDTH-1:0]    i_alloc_addr,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_alloc_data,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_alloc_tag,
    input  logic                          i_rob_retire_en,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_rob_retire_tag,
    input  logic                          i_fill_en,
    output logic                          o_full,
    output logic                          o_rob_retire_ack,
    output logic                          o_drain_en,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_drain_addr,
    output logic [`LSU_DATA_WIDTH-1:0]    o_drain_data,
    output lsu_pkg::byte_mask_t           o_drain_mask
);

    import lsu_pkg::*;

    localparam int               PTR_W = $clog2(`LSU_SQ_DEPTH) + 1;
    localparam logic [PTR_W-1:0] DEPTH = PTR_W'(`LSU_SQ_DEPTH);

    logic [PTR_W-1:0]              head_q;
    logic [PTR_W-1:0]              ret_q;
    logic [PTR_W-1:0]              drain_lim_q;
    logic [PTR_W-1:0]              tail_q;
    logic [PTR_W-1:0]              ret_next;
    logic [PTR_W-1:0]              count;
    logic                          retire_match;
    logic [`LSU_DATA_WIDTH-1:0]    alloc_lanes;
    byte_mask_t                    alloc_mask;
    logic [`LSU_ADDR_WIDTH-1:0]    addr_mem [`LSU_SQ_DEPTH];
    logic [`LSU_DATA_WIDTH-1:0]    data_mem [`LSU_SQ_DEPTH];
    byte_mask_t                    mask_mem [`LSU_SQ_DEPTH];
    logic [`LSU_ROB_TAG_WIDTH-1:0] tag_mem  [`LSU_SQ_DEPTH];

    // Head to ret_q is retired, ret_q to tail_q is still speculative.
    assign count    = tail_q - head_q;
    assign o_full   = (count == DEPTH) || (i_alloc_en && (count == DEPTH - 1'b1));

    assign retire_match = i_rob_retire_en && (ret_q != tail_q) &&
                          (tag_mem[ret_q[PTR_W-2:0]] == i_rob_retire_tag);
    assign ret_next     = ret_q + PTR_W'(retire_match);

    // Fills own the cache write port, so a drain waits for a free cycle.
    assign o_drain_en   = (head_q != drain_lim_q) && !i_fill_en;
    assign o_drain_addr = addr_mem[head_q[PTR_W-2:0]];
    assign o_drain_data = data_mem[head_q[PTR_W-2:0]];
    assign o_drain_mask = mask_mem[head_q[PTR_W-2:0]];

    always_comb begin
        alloc_lanes = i_alloc_data << {i_alloc_addr[1:0], 3'b000};
        case (i_alloc_func)
            LSU_SB:  alloc_mask = byte_mask_t'(1);
            LSU_SH:  alloc_mask = byte_mask_t'(3);
            default: alloc_mask = '1;
        endcase
        alloc_mask = alloc_mask << i_alloc_addr[1:0];
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q           <= '0;
            ret_q            <= '0;
            drain_lim_q      <= '0;
            tail_q           <= '0;
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= retire_match;
            ret_q            <= ret_next;
            drain_lim_q      <= ret_q;
            if (o_drain_en) begin
                head_q <= head_q + 1'b1;
            end
            // Speculative stores are dropped and the tail falls back.
            if (i_flush) begin
                tail_q <= ret_next;
            end else if (i_alloc_en) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_alloc_en && !i_flush) begin
            addr_mem[tail_q[PTR_W-2:0]] <= {i_alloc_addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
            data_mem[tail_q[PTR_W-2:0]] <= alloc_lanes;
            mask_mem[tail_q[PTR_W-2:0]] <= alloc_mask;
            tag_mem[tail_q[PTR_W-2:0]]  <= i_alloc_tag;
        end
    end

    // The address stage must hold back stores once every entry is taken.
    assert property (@(posedge clk) disable iff (!i_rst_n)
        i_alloc_en |-> (count != DEPTH));

endmodule

// ==== source/lsu_top.sv ====
// Top level of the load/store unit, connects the address stage, store queue, cache and execute.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic                          i_flush,
    input  logic                          i_fu_valid,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_insn,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_src_a,
    input  logic [`LSU_DATA_WIDTH-1:0]    i_fu_src_b,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_fu_tag,
    output logic                          o_fu_stall,
    output logic                          o_cdb_en,
    output logic [`LSU_DATA_WIDTH-1:0]    o_cdb_data,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_cdb_addr,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_cdb_tag,
    output logic                          o_miss_en,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_miss_addr,
    output logic [`LSU_ROB_TAG_WIDTH-1:0] o_miss_tag,
    input  logic                          i_fill_en,
    input  logic [`LSU_ADDR_WIDTH-1:0]    i_fill_addr,
    input  lsu_pkg::dc_line_t             i_fill_data,
    input  logic                          i_rob_retire_sq_en,
    input  logic [`LSU_ROB_TAG_WIDTH-1:0] i_rob_retire_tag,
    output logic                          o_rob_retire_sq_ack,
    output logic                          o_mem_wr_en,
    output logic [`LSU_ADDR_WIDTH-1:0]    o_mem_wr_addr,
    output logic [`LSU_DATA_WIDTH-1:0]    o_mem_wr_data,
    output lsu_pkg::byte_mask_t           o_mem_wr_mask
);

    import lsu_pkg::*;

    logic                          sq_full;
    logic                          rd_en;
    logic [`LSU_ADDR_WIDTH-1:0]    rd_addr;
    logic                          alloc_en;
    lsu_func_t                     alloc_func;
    logic [`LSU_ADDR_WIDTH-1:0]    alloc_addr;
    logic [`LSU_DATA_WIDTH-1:0]    alloc_data;
    logic [`LSU_ROB_TAG_WIDTH-1:0] alloc_tag;
    logic                          ag_valid;
    lsu_func_t                     ag_func;
    logic [`LSU_ADDR_WIDTH-1:0]    ag_addr;
    logic [`LSU_ROB_TAG_WIDTH-1:0] ag_tag;
    logic                          dc_hit;
    logic [`LSU_DATA_WIDTH-1:0]    dc_rd_word;

    lsu_agu agu_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),
        .i_fu_valid(i_fu_valid),
        .i_fu_insn(i_fu_insn),
        .i_fu_src_a(i_fu_src_a),
        .i_fu_src_b(i_fu_src_b),
        .i_fu_tag(i_fu_tag),
        .i_sq_full(sq_full),
        .o_fu_stall(o_fu_stall),
        .o_rd_en(rd_en),
        .o_rd_addr(rd_addr),
        .o_alloc_en(alloc_en),
        .o_alloc_func(alloc_func),
        .o_alloc_addr(alloc_addr),
        .o_alloc_data(alloc_data),
        .o_alloc_tag(alloc_tag),
        .o_valid(ag_valid),
        .o_func(ag_func),
        .o_addr(ag_addr),
        .o_tag(ag_tag)
    );

    // The drain port writes the cache and memory together.
    lsu_store_queue store_queue_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),
        .i_alloc_en(alloc_en),
        .i_alloc_func(alloc_func),
        .i_alloc_addr(alloc_addr),
        .i_alloc_data(alloc_data),
        .i_alloc_tag(alloc_tag),
        .i_rob_retire_en(i_rob_retire_sq_en),
        .i_rob_retire_tag(i_rob_retire_tag),
        .i_fill_en(i_fill_en),
        .o_full(sq_full),
        .o_rob_retire_ack(o_rob_retire_sq_ack),
        .o_drain_en(o_mem_wr_en),
        .o_drain_addr(o_mem_wr_addr),
        .o_drain_data(o_mem_wr_data),
        .o_drain_mask(o_mem_wr_mask)
    );

    lsu_dcache dcache_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rd_en(rd_en),
        .i_rd_addr(rd_addr),
        .i_fill_en(i_fill_en),
        .i_fill_addr(i_fill_addr),
        .i_fill_data(i_fill_data),
        .i_st_en(o_mem_wr_en),
        .i_st_addr(o_mem_wr_addr),
        .i_st_data(o_mem_wr_data),
        .i_st_mask(o_mem_wr_mask),
        .o_hit(dc_hit),
        .o_rd_word(dc_rd_word)
    );

    lsu_execute execute_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_flush(i_flush),
        .i_valid(ag_valid),
        .i_func(ag_func),
        .i_addr(ag_addr),
        .i_tag(ag_tag),
        .i_hit(dc_hit),
        .i_rd_word(dc_rd_word),
        .o_cdb_en(o_cdb_en),
        .o_cdb_data(o_cdb_data),
        .o_cdb_addr(o_cdb_addr),
        .o_cdb_tag(o_cdb_tag),
        .o_miss_en(o_miss_en),
        .o_miss_addr(o_miss_addr),
        .o_miss_tag(o_miss_tag)
    );

endmodule

// ==== verification/tb_lsu_top.sv ====
// Directed testbench of the LSU top level, run through lsu_top.f with the Verilator script.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int BUDGET_CYCLES = 60 + 320 + 200 + 200 + 160;

    logic clk = 1'b0;
    logic i_rst_n, i_flush, i_fu_valid, i_fill_en, i_rob_retire_sq_en;
    logic [31:0] i_fu_insn, i_fu_src_a, i_fu_src_b, i_fill_addr;
    logic [4:0] i_fu_tag, i_rob_retire_tag;
    dc_line_t i_fill_data;
    logic o_fu_stall, o_cdb_en, o_miss_en, o_rob_retire_sq_ack, o_mem_wr_en;
    logic [31:0] o_cdb_data, o_cdb_addr, o_miss_addr, o_mem_wr_addr, o_mem_wr_data;
    logic [4:0] o_cdb_tag, o_miss_tag;
    byte_mask_t o_mem_wr_mask;

    // Reference model of memory and of the lines held in the cache.
    logic [7:0] mem [int unsigned];
    logic [31:0] res_line [16];
    bit res_valid [16];
    logic [31:0] drain_addr_q [$];
    logic [31:0] drain_data_q [$];
    logic [3:0] drain_mask_q [$];
    int errors = 0;
    int cdb_count = 0;
    int miss_count = 0;

    lsu_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [7:0] mem_byte(logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;
    endfunction

    function automatic logic [31:0] expect_load(logic [2:0] f3, logic [31:0] a);
        logic [31:0] wa, w, s;
        wa = {a[31:2], 2'b00};
        w = {mem_byte(wa + 3), mem_byte(wa + 2), mem_byte(wa + 1), mem_byte(wa)};
        s = w >> (8 * a[1:0]);
        case (f3)
            3'd0: return {{24{s[7]}}, s[7:0]};
            3'd1: return {{16{s[15]}}, s[15:0]};
            3'd4: return {24'h0, s[7:0]};
            3'd5: return {16'h0, s[15:0]};
            default: return s;
        endcase
    endfunction

    function automatic bit is_resident(logic [31:0] a);
        return res_valid[a[7:4]] && (res_line[a[7:4]] == {a[31:4], 4'h0});
    endfunction

    function automatic logic [31:0] load_insn(logic [2:0] f3, logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_insn(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Drained stores update memory, and the cache copy follows it.
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (o_cdb_en) cdb_count++;
            if (o_miss_en) miss_count++;
            if (o_mem_wr_en) begin
                drain_addr_q.push_back(o_mem_wr_addr);
                drain_data_q.push_back(o_mem_wr_data);
                drain_mask_q.push_back(o_mem_wr_mask);
                for (int b = 0; b < 4; b++) begin
                    if (o_mem_wr_mask[b]) mem[o_mem_wr_addr + b] = o_mem_wr_data[8*b +: 8];
                end
            end
        end
    end

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clk);
        #0.5;
    endtask

    // Holds the operation on the issue inputs until an edge with no stall.
    task automatic issue_op(logic [31:0] insn, logic [31:0] a, logic [31:0] b, logic [4:0] tag);
        logic stalled;
        i_fu_insn = insn;
        i_fu_src_a = a;
        i_fu_src_b = b;
        i_fu_tag = tag;
        i_fu_valid = 1'b1;
        forever begin
            @(negedge clk);
            stalled = o_fu_stall;
            @(posedge clk);
            if (!stalled) break;
        end
        #0.5;
        i_fu_valid = 1'b0;
    endtask

    task automatic await_result(bit miss, logic [31:0] data, logic [31:0] addr, logic [4:0] tag);
        int k;
        k = 1;
        forever begin
            @(negedge clk);
            if (o_cdb_en || o_miss_en || k >= 10) break;
            @(posedge clk);
            k++;
        end
        if (!(o_cdb_en || o_miss_en)) begin
            $display("No result or miss pulse for tag %0d within 10 cycles", tag);
            errors++;
        end else begin
            compare("latency", 3, k);
            compare("o_miss_en", miss, o_miss_en);
            compare("o_cdb_en", !miss, o_cdb_en);
            compare(miss ? "o_miss_addr" : "o_cdb_addr", addr, miss ? o_miss_addr : o_cdb_addr);
            compare(miss ? "o_miss_tag" : "o_cdb_tag", tag, miss ? o_miss_tag : o_cdb_tag);
            if (!miss) compare("o_cdb_data", data, o_cdb_data);
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic run_load(logic [2:0] f3, logic [31:0] base, logic [11:0] off, logic [4:0] tag);
        logic [31:0] a;
        a = base + {{20{off[11]}}, off};
        issue_op(load_insn(f3, off), base, 32'h0, tag);
        await_result(!is_resident(a), expect_load(f3, a), a, tag);
    endtask

    task automatic run_store(logic [2:0] f3, logic [31:0] base, logic [11:0] off,
                             logic [31:0] d, logic [4:0] tag);
        issue_op(store_insn(f3, off), base, d, tag);
        await_result(1'b0, 32'h0, base + {{20{off[11]}}, off}, tag);
    endtask

    task automatic retire_store(logic [4:0] tag, bit ack);
        i_rob_retire_tag = tag;
        i_rob_retire_sq_en = 1'b1;
        @(posedge clk);
        #0.5;
        i_rob_retire_sq_en = 1'b0;
        @(negedge clk);
        compare("o_rob_retire_sq_ack", ack, o_rob_retire_sq_ack);
        @(posedge clk);
        #0.5;
    endtask

    task automatic wait_drains(int n);
        int c;
        c = 0;
        while (drain_addr_q.size() < n && c < 20) begin
            @(posedge clk);
            c++;
        end
        #0.5;
        if (drain_addr_q.size() < n) begin
            $display("Store drain did not reach memory, %0d of %0d seen", drain_addr_q.size(), n);
            errors++;
        end
    endtask

    task automatic check_drain(int idx, logic [31:0] a, logic [31:0] d, logic [3:0] m);
        if (idx < drain_addr_q.size()) begin
            compare("o_mem_wr_addr", a, drain_addr_q[idx]);
            compare("o_mem_wr_data", d, drain_data_q[idx]);
            compare("o_mem_wr_mask", m, drain_mask_q[idx]);
        end
    endtask

    task automatic fill_line(logic [31:0] line);
        for (int b = 0; b < 16; b++) i_fill_data[8*b +: 8] = mem_byte(line + b);
        i_fill_addr = line;
        i_fill_en = 1'b1;
        @(posedge clk);
        #0.5;
        i_fill_en = 1'b0;
        res_valid[line[7:4]] = 1'b1;
        res_line[line[7:4]] = line;
    endtask

    task automatic reset_then_miss();
        @(negedge clk);
        compare("o_fu_stall", 0, o_fu_stall);
        compare("o_cdb_en", 0, o_cdb_en);
        compare("o_miss_en", 0, o_miss_en);
        compare("o_rob_retire_sq_ack", 0, o_rob_retire_sq_ack);
        compare("o_mem_wr_en", 0, o_mem_wr_en);
        wait_cycles(1);
        run_load(3'd2, 32'h1000, 12'h0, 5'd3);
    endtask

    task automatic load_functions();
        fill_line(32'h1000);
        for (int off = 0; off < 16; off++) begin
            run_load(3'd0, 32'h1000, off, 5'd1);
            run_load(3'd4, 32'h1000, off, 5'd2);
            if (off % 2 == 0) run_load(3'd1, 32'h1000, off, 5'd3);
            if (off % 2 == 0) run_load(3'd5, 32'h1000, off, 5'd4);
            if (off % 4 == 0) run_load(3'd2, 32'h1000, off, 5'd5);
        end
    endtask

    task automatic store_drain_merge();
        logic [31:0] d, e;
        d = $urandom;
        e = $urandom;
        fill_line(32'h2040);
        run_store(3'd0, 32'h2000, 12'h041, d, 5'd7);
        retire_store(5'd7, 1'b1);
        wait_drains(1);
        check_drain(0, 32'h2040, d << 8, 4'b0010);
        run_load(3'd2, 32'h2040, 12'h0, 5'd8);
        run_store(3'd1, 32'h3002, 12'h0, e, 5'd9);
        retire_store(5'd9, 1'b1);
        wait_drains(2);
        check_drain(1, 32'h3000, e << 16, 4'b1100);
        run_load(3'd1, 32'h3000, 12'h2, 5'd10);
        wait_cycles(4);
        compare("drain count", 2, drain_addr_q.size());
    endtask

    task automatic full_queue_stall();
        int base_cdb;
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            run_store(3'd2, 32'h4000 + 4 * i, 12'h0, $urandom, 10 + i);
        end
        base_cdb = cdb_count;
        fork
            run_load(3'd2, 32'h1000, 12'h4, 5'd30);
            begin
                repeat (4) begin
                    @(negedge clk);
                    compare("o_fu_stall", 1, o_fu_stall);
                    compare("o_cdb_en", 0, o_cdb_en);
                end
                @(posedge clk);
                #0.5;
                retire_store(5'd10, 1'b1);
            end
        join
        wait_cycles(5);
        compare("cdb pulses after stall", base_cdb + 1, cdb_count);
        for (int i = 1; i < `LSU_SQ_DEPTH; i++) retire_store(10 + i, 1'b1);
        wait_drains(6);
    endtask

    task automatic flush_in_flight();
        int base_cdb, base_miss, base_drain;
        base_cdb = cdb_count;
        base_miss = miss_count;
        issue_op(load_insn(3'd2, 12'h8), 32'h1000, 32'h0, 5'd1);
        issue_op(load_insn(3'd2, 12'h0), 32'h5000, 32'h0, 5'd2);
        i_flush = 1'b1;
        wait_cycles(1);
        i_flush = 1'b0;
        wait_cycles(6);
        compare("cdb pulses after flush", base_cdb, cdb_count);
        compare("miss pulses after flush", base_miss, miss_count);
        base_drain = drain_addr_q.size();
        for (int i = 0; i < 3; i++) begin
            run_store(3'd2, 32'h6000 + 16 * i, 12'h0, 32'h100 + i, 20 + i);
        end
        retire_store(5'd20, 1'b1);
        // The second store retires on the edge before the flush and drains after it.
        i_rob_retire_tag = 5'd21;
        i_rob_retire_sq_en = 1'b1;
        wait_cycles(1);
        i_rob_retire_sq_en = 1'b0;
        i_flush = 1'b1;
        @(negedge clk);
        compare("o_rob_retire_sq_ack", 1, o_rob_retire_sq_ack);
        wait_cycles(1);
        i_flush = 1'b0;
        retire_store(5'd22, 1'b0);
        wait_drains(base_drain + 2);
        wait_cycles(8);
        compare("drain count after flush", base_drain + 2, drain_addr_q.size());
        check_drain(base_drain, 32'h6000, 32'h100, 4'hf);
        check_drain(base_drain + 1, 32'h6010, 32'h101, 4'hf);
    endtask

    initial begin
        #(2 * BUDGET_CYCLES * 4);
        $display("Watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(71));
        i_rst_n = 1'b0;
        {i_flush, i_fu_valid, i_fill_en, i_rob_retire_sq_en} = '0;
        {i_fu_insn, i_fu_src_a, i_fu_src_b, i_fill_addr} = '0;
        i_fu_tag = '0;
        i_rob_retire_tag = '0;
        i_fill_data = '0;
        repeat (3) @(posedge clk);
        #0.5;
        i_rst_n = 1'b1;
        reset_then_miss();
        load_functions();
        store_drain_merge();
        full_queue_stall();
        flush_in_flight();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
